// ==== design/aout_pkg.sv ====
`default_nettype none

package aout_pkg;

    // ------------------------------------------------------------------------
    // Widths

    localparam int SAMPLE_W   = 16;
    localparam int ADDR_W     = 4;
    localparam int DATA_W     = 32;
    localparam int INTERVAL_W = 8;
    localparam int LEVEL_W    = 3;

    // ------------------------------------------------------------------------
    // Register map

    localparam logic [ADDR_W-1:0] REG_CSR    = 4'h0;
    localparam logic [ADDR_W-1:0] REG_SAMPLE = 4'h4;

    // CSR field positions
    localparam int CSR_ENABLE_BIT   = 0;
    localparam int CSR_SIGNED_BIT   = 1;
    localparam int CSR_INTERVAL_LSB = 8;
    localparam int CSR_LEVEL_LSB    = 16;

    // One stereo pair with the left channel in the upper half
    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } stereo_t;

    typedef struct packed {
        logic                  enable;
        logic                  is_signed;
        logic [INTERVAL_W-1:0] interval;
        logic [LEVEL_W-1:0]    irq_level;
    } aout_ctrl_t;

    // Write strobe payload
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire

// ==== design/aout_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module aout_regs (
    input  wire                  clk_sys,
    input  wire                  rst_n_sys,

    input  wire                  wr_valid_i,
    input  aout_pkg::reg_wr_t    wr_i,

    output aout_pkg::aout_ctrl_t ctrl_o,
    output logic                 push_o,
    output aout_pkg::stereo_t    push_data_o
);

    localparam int SW = aout_pkg::SAMPLE_W;
    localparam int DW = aout_pkg::DATA_W;

    aout_pkg::aout_ctrl_t ctrl_q;
    logic                 csr_wr;
    logic [SW-1:0]        msb_flip;

    // ------------------------------------------------------------------------
    // Address decode

    assign csr_wr = wr_valid_i && (wr_i.addr == aout_pkg::REG_CSR);
    assign push_o = wr_valid_i && (wr_i.addr == aout_pkg::REG_SAMPLE);

    // ------------------------------------------------------------------------
    // Control register

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            ctrl_q <= '0;
        end else if (csr_wr) begin
            ctrl_q.enable    <= wr_i.data[aout_pkg::CSR_ENABLE_BIT];
            ctrl_q.is_signed <= wr_i.data[aout_pkg::CSR_SIGNED_BIT];
            ctrl_q.interval  <=
                wr_i.data[aout_pkg::CSR_INTERVAL_LSB +: aout_pkg::INTERVAL_W];
            ctrl_q.irq_level <=
                wr_i.data[aout_pkg::CSR_LEVEL_LSB +: aout_pkg::LEVEL_W];
        end
    end

    assign ctrl_o = ctrl_q;

    // ------------------------------------------------------------------------
    // Sample push

    // Inverting the MSB maps two's complement onto offset binary
    assign msb_flip = {ctrl_q.is_signed, {(SW-1){1'b0}}};

    always_comb begin
        push_data_o.left  = wr_i.data[DW-1 -: SW] ^ msb_flip;
        push_data_o.right = wr_i.data[SW-1:0] ^ msb_flip;
    end

endmodule

`default_nettype wire

// ==== design/sample_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                          clk_sys,
    input  wire                          rst_n_sys,

    input  wire                          push_i,
    input  aout_pkg::stereo_t            push_data_i,

    input  wire                          pop_i,
    output aout_pkg::stereo_t            head_o,
    output logic                         empty_o,
    output logic [aout_pkg::LEVEL_W-1:0] level_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [aout_pkg::LEVEL_W-1:0] FULL_LEVEL =
        FIFO_DEPTH[aout_pkg::LEVEL_W-1:0];

    aout_pkg::stereo_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic [aout_pkg::LEVEL_W-1:0]  level_q;
    logic                          full;
    logic                          push_ok;
    logic                          pop_ok;

    // Wraps at FIFO_DEPTH so non power of two depths also work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (level_q == FULL_LEVEL);
    assign empty_o = (level_q == '0);
    assign push_ok = push_i && !full;
    assign pop_ok  = pop_i && !empty_o;

    // ------------------------------------------------------------------------
    // Pointers and level

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the level alone
            if (push_ok && !pop_ok) begin
                level_q <= level_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                level_q <= level_q - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Storage

    always_ff @(posedge clk_sys) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    assign head_o  = mem[rd_ptr];
    assign level_o = level_q;

endmodule

`default_nettype wire

// ==== design/pwm_player.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_player #(
    parameter int PWM_BITS = 6
) (
    input  wire                             clk_sys,
    input  wire                             rst_n_sys,

    input  wire                             enable_i,
    input  wire [aout_pkg::INTERVAL_W-1:0]  interval_i,

    input  aout_pkg::stereo_t               head_i,
    input  wire                             empty_i,
    output logic                            pop_o,

    output logic                            audio_l_o,
    output logic                            audio_r_o
);

    localparam int SW = aout_pkg::SAMPLE_W;

    logic [PWM_BITS-1:0]             cnt;
    logic [aout_pkg::INTERVAL_W-1:0] rep_cnt;
    aout_pkg::stereo_t               sample_q;
    logic                            period_end;
    logic                            rep_done;

    assign period_end = enable_i && (cnt == '1);
    // Greater-or-equal so that lowering the interval mid-sample cannot stall
    assign rep_done   = (rep_cnt >= interval_i);
    assign pop_o      = period_end && rep_done && !empty_i;

    // ------------------------------------------------------------------------
    // Period and repeat counters

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            cnt     <= '0;
            rep_cnt <= '0;
        end else if (!enable_i) begin
            cnt     <= '0;
            rep_cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            if (period_end) begin
                if (pop_o) begin
                    rep_cnt <= '0;
                end else if (!rep_done) begin
                    rep_cnt <= rep_cnt + 1'b1;
                end
                // On underrun the count stays put and the old sample replays
            end
        end
    end

    // Zero at reset, so the first period after enable is fully low
    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            sample_q <= '0;
        end else if (pop_o) begin
            sample_q <= head_i;
        end
    end

    // ------------------------------------------------------------------------
    // Duty cycle compare against the top PWM_BITS of each channel

    assign audio_l_o = enable_i && (cnt < sample_q.left[SW-1 -: PWM_BITS]);
    assign audio_r_o = enable_i && (cnt < sample_q.right[SW-1 -: PWM_BITS]);

endmodule

`default_nettype wire

// ==== design/audio_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_out #(
    parameter int FIFO_DEPTH = 4,
    parameter int PWM_BITS   = 6
) (
    input  wire                          clk_sys,
    input  wire                          rst_n_sys,

    input  wire                          wr_valid_i,
    input  aout_pkg::reg_wr_t            wr_i,

    output logic [aout_pkg::LEVEL_W-1:0] level_o,
    output logic                         irq_o,

    output logic                         audio_l_o,
    output logic                         audio_r_o
);

    aout_pkg::aout_ctrl_t          ctrl;
    logic                          push;
    aout_pkg::stereo_t             push_data;
    logic                          pop;
    aout_pkg::stereo_t             head;
    logic                          empty;
    logic [aout_pkg::LEVEL_W-1:0]  level;

    // ------------------------------------------------------------------------
    // Register stage

    aout_regs aout_regs_u (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .wr_valid_i  (wr_valid_i),
        .wr_i        (wr_i),
        .ctrl_o      (ctrl),
        .push_o      (push),
        .push_data_o (push_data)
    );

    // ------------------------------------------------------------------------
    // Queue stage

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sample_fifo_u (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty),
        .level_o     (level)
    );

    // ------------------------------------------------------------------------
    // Player stage

    pwm_player #(
        .PWM_BITS (PWM_BITS)
    ) pwm_player_u (
        .clk_sys    (clk_sys),
        .rst_n_sys  (rst_n_sys),
        .enable_i   (ctrl.enable),
        .interval_i (ctrl.interval),
        .head_i     (head),
        .empty_i    (empty),
        .pop_o      (pop),
        .audio_l_o  (audio_l_o),
        .audio_r_o  (audio_r_o)
    );

    // Low-water interrupt asking software to refill the queue
    assign irq_o   = (level <= ctrl.irq_level);
    assign level_o = level;

endmodule

`default_nettype wire

// ==== verification/audio_out_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_out_properties #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                          clk_sys,
    input  wire                          rst_n_sys,
    input  wire [aout_pkg::LEVEL_W-1:0]  level_i,
    input  aout_pkg::aout_ctrl_t         ctrl_i,
    input  wire                          pop_i,
    input  wire                          empty_i,
    input  wire                          irq_i,
    input  wire                          audio_l_i,
    input  wire                          audio_r_i
);

    // Number of failed assertions
    int fail_count = 0;

    level_bound_a: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        int'(level_i) <= FIFO_DEPTH)
        else begin
            fail_count++;
            $error("Queue level above its depth");
        end

    quiet_when_off_a: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        !ctrl_i.enable |-> (!audio_l_i && !audio_r_i))
        else begin
            fail_count++;
            $error("Audio output high while disabled");
        end

    irq_rule_a: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        irq_i == (level_i <= ctrl_i.irq_level))
        else begin
            fail_count++;
            $error("Interrupt does not match the level threshold");
        end

    no_empty_pop_a: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        pop_i |-> !empty_i)
        else begin
            fail_count++;
            $error("Pop issued on an empty queue");
        end

endmodule

bind audio_out audio_out_properties #(
    .FIFO_DEPTH (FIFO_DEPTH)
) audio_out_props_u (
    .clk_sys   (clk_sys),
    .rst_n_sys (rst_n_sys),
    .level_i   (level),
    .ctrl_i    (ctrl),
    .pop_i     (pop),
    .empty_i   (empty),
    .irq_i     (irq_o),
    .audio_l_i (audio_l_o),
    .audio_r_i (audio_r_o)
);

`default_nettype wire

// ==== verification/audio_out_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_out_checker #(
    parameter int FIFO_DEPTH = 4,
    parameter int PWM_BITS   = 6
) (
    input  wire                          clk_sys,
    input  wire                          rst_n_sys,
    input  wire                          wr_valid_i,
    input  aout_pkg::reg_wr_t            wr_i,
    input  wire [aout_pkg::LEVEL_W-1:0]  level_i,
    input  wire                          irq_i,
    input  wire                          audio_l_i,
    input  wire                          audio_r_i,
    input  wire [7:0]                    test_i,
    output int                           checks_o,
    output int                           errors_o
);

    localparam int SW = aout_pkg::SAMPLE_W;

    aout_pkg::stereo_t    model_q[$];
    aout_pkg::stereo_t    cur;
    aout_pkg::aout_ctrl_t ctrl;
    int                   cnt;
    int                   rep;
    int                   test_errors;
    logic [7:0]           last_test;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks_o++;
        if (actual !== expected) begin
            errors_o++;
            test_errors++;
            $display("FAILED test %0d: %s expected %h got %h at %0t ns",
                     last_test, name, expected, actual, $time);
        end
    endtask

    // High while the period count is below the channel's top bits
    function automatic logic duty_bit(input logic [SW-1:0] chan);
        return ctrl.enable && (cnt < int'(chan[SW-1 -: PWM_BITS]));
    endfunction

    // ------------------------------------------------------------------------
    // Reference model stepped once per clock

    task automatic advance_model();
        int                size0;
        aout_pkg::stereo_t pair;
        size0 = model_q.size();
        if (ctrl.enable) begin
            if (cnt == (1 << PWM_BITS) - 1) begin
                // rep counts finished periods of the current sample minus one
                if (rep >= int'(ctrl.interval)) begin
                    if (size0 > 0) begin
                        cur = model_q.pop_front();
                        rep = 0;
                    end
                end else begin
                    rep++;
                end
                cnt = 0;
            end else begin
                cnt++;
            end
        end else begin
            cnt = 0;
            rep = 0;
        end
        if (wr_valid_i && wr_i.addr == aout_pkg::REG_SAMPLE && size0 < FIFO_DEPTH) begin
            pair.left  = wr_i.data[31:16];
            pair.right = wr_i.data[15:0];
            if (ctrl.is_signed) begin
                pair.left[SW-1]  = ~pair.left[SW-1];
                pair.right[SW-1] = ~pair.right[SW-1];
            end
            model_q.push_back(pair);
        end
        if (wr_valid_i && wr_i.addr == aout_pkg::REG_CSR) begin
            ctrl.enable    = wr_i.data[aout_pkg::CSR_ENABLE_BIT];
            ctrl.is_signed = wr_i.data[aout_pkg::CSR_SIGNED_BIT];
            ctrl.interval  = wr_i.data[aout_pkg::CSR_INTERVAL_LSB +: aout_pkg::INTERVAL_W];
            ctrl.irq_level = wr_i.data[aout_pkg::CSR_LEVEL_LSB +: aout_pkg::LEVEL_W];
        end
    endtask

    always @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            model_q.delete();
            cur         = '0;
            ctrl        = '0;
            cnt         = 0;
            rep         = 0;
            checks_o    = 0;
            errors_o    = 0;
            test_errors = 0;
            last_test   = '0;
        end else begin
            if (test_i != last_test) begin
                if (last_test != '0) begin
                    $display("Test %0d done, %0d mismatches", last_test, test_errors);
                end
                last_test   = test_i;
                test_errors = 0;
            end
            compare("level_o", 32'(model_q.size()), 32'(level_i));
            compare("irq_o", 32'(model_q.size() <= int'(ctrl.irq_level)), 32'(irq_i));
            compare("audio_l_o", 32'(duty_bit(cur.left)), 32'(audio_l_i));
            compare("audio_r_o", 32'(duty_bit(cur.right)), 32'(audio_r_i));
            advance_model();
        end
    end

endmodule

`default_nettype wire

// ==== verification/audio_out_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_out_tb;

    localparam int FIFO_DEPTH = 4;
    localparam int PWM_BITS   = 6;
    localparam int CLK_PERIOD = 20;
    localparam int WINDOW     = 1 << PWM_BITS;

    // One table row whose wait_cyc includes the strobe cycle
    typedef struct packed {
        logic [aout_pkg::ADDR_W-1:0] addr;
        logic [aout_pkg::DATA_W-1:0] data;
        logic [15:0]                 wait_cyc;
        logic [7:0]                  test;
    } step_t;

    logic                         clk_sys;
    logic                         rst_n_sys;
    logic                         wr_valid_i;
    aout_pkg::reg_wr_t            wr_i;
    logic [aout_pkg::LEVEL_W-1:0] level_o;
    logic                         irq_o;
    logic                         audio_l_o;
    logic                         audio_r_o;

    logic [7:0] cur_test;
    int         checks;
    int         errors;
    int         assert_fails;
    int         seed;
    int         watchdog_ns;
    logic       table_ready;
    step_t      steps[$];

    audio_out #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PWM_BITS   (PWM_BITS)
    ) audio_out_i (
        .clk_sys    (clk_sys),
        .rst_n_sys  (rst_n_sys),
        .wr_valid_i (wr_valid_i),
        .wr_i       (wr_i),
        .level_o    (level_o),
        .irq_o      (irq_o),
        .audio_l_o  (audio_l_o),
        .audio_r_o  (audio_r_o)
    );

    audio_out_checker #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PWM_BITS   (PWM_BITS)
    ) checker_u (
        .clk_sys    (clk_sys),
        .rst_n_sys  (rst_n_sys),
        .wr_valid_i (wr_valid_i),
        .wr_i       (wr_i),
        .level_i    (level_o),
        .irq_i      (irq_o),
        .audio_l_i  (audio_l_o),
        .audio_r_i  (audio_r_o),
        .test_i     (cur_test),
        .checks_o   (checks),
        .errors_o   (errors)
    );

    function automatic logic [31:0] csr_word(input logic en, input logic sgn,
                                             input int interval, input int irq_level);
        logic [31:0] w;
        w = '0;
        w[aout_pkg::CSR_ENABLE_BIT] = en;
        w[aout_pkg::CSR_SIGNED_BIT] = sgn;
        w[aout_pkg::CSR_INTERVAL_LSB +: aout_pkg::INTERVAL_W] =
            interval[aout_pkg::INTERVAL_W-1:0];
        w[aout_pkg::CSR_LEVEL_LSB +: aout_pkg::LEVEL_W] = irq_level[aout_pkg::LEVEL_W-1:0];
        return w;
    endfunction

    task automatic add_step(input logic [3:0] addr, input logic [31:0] data,
                            input int wait_cyc, input int test);
        step_t s;
        s.addr     = addr;
        s.data     = data;
        s.wait_cyc = wait_cyc[15:0];
        s.test     = test[7:0];
        steps.push_back(s);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table

    task automatic build_table();
        // Fill level with the player idle and the fifth push hitting a full queue
        add_step(aout_pkg::REG_CSR, csr_word(1'b0, 1'b0, 0, 0), 2, 1);
        repeat (5) add_step(aout_pkg::REG_SAMPLE, $random(seed), 2, 1);
        // Low-water threshold of 2
        add_step(aout_pkg::REG_CSR, csr_word(1'b0, 1'b0, 0, 2), 4, 2);
        // One window per sample followed by signed samples
        add_step(aout_pkg::REG_CSR, csr_word(1'b1, 1'b0, 0, 2), 5 * WINDOW, 3);
        add_step(aout_pkg::REG_CSR, csr_word(1'b1, 1'b1, 0, 2), 2, 3);
        add_step(aout_pkg::REG_SAMPLE, $random(seed), 2, 3);
        add_step(aout_pkg::REG_SAMPLE, $random(seed), 3 * WINDOW, 3);
        // Three windows per sample
        add_step(aout_pkg::REG_CSR, csr_word(1'b1, 1'b1, 2, 2), 2, 4);
        add_step(aout_pkg::REG_SAMPLE, $random(seed), 2, 4);
        add_step(aout_pkg::REG_SAMPLE, $random(seed), 2, 4);
        add_step(aout_pkg::REG_SAMPLE, $random(seed), 10 * WINDOW, 4);
        // Unmapped address and underrun replay before the disable
        add_step(4'hC, $random(seed), 4 * WINDOW, 5);
        add_step(aout_pkg::REG_CSR, csr_word(1'b0, 1'b1, 2, 2), 20, 5);
    endtask

    task automatic apply_step(input step_t s);
        cur_test   = s.test;
        wr_i.addr  = s.addr;
        wr_i.data  = s.data;
        wr_valid_i = 1'b1;
        repeat (s.wait_cyc) begin
            @(posedge clk_sys);
            #2;
            wr_valid_i = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // Clock, stimulus and watchdog

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    initial begin : stimulus
        int total;
        seed        = 45201;
        rst_n_sys   = 1'b0;
        wr_valid_i  = 1'b0;
        wr_i        = '0;
        cur_test    = '0;
        table_ready = 1'b0;
        build_table();
        total = 0;
        foreach (steps[i]) begin
            total += int'(steps[i].wait_cyc);
        end
        watchdog_ns = (total + 50) * CLK_PERIOD;
        table_ready = 1'b1;
        repeat (8) @(posedge clk_sys);
        #2;
        rst_n_sys = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        // Test 0 closes the report of the last test
        cur_test = '0;
        repeat (2) @(posedge clk_sys);
        #2;
        assert_fails = audio_out_i.audio_out_props_u.fail_count;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && checks > 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            if (checks == 0) begin
                $display("No comparisons were made by the checker");
            end
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #(watchdog_ns);
        $display("Timeout: stimulus did not finish within %0d ns", watchdog_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== audio_out.f ====
design/aout_pkg.sv
design/aout_regs.sv
design/sample_fifo.sv
design/pwm_player.sv
design/audio_out.sv
verification/audio_out_properties.sv
verification/audio_out_checker.sv
verification/audio_out_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the audio_out testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal --top-module audio_out_tb \
    -f audio_out.f -Mdir build/obj_dir -o audio_out_sim

./build/obj_dir/audio_out_sim +verilator+error+limit+100 | tee build/sim.log

if grep -q "TESTBENCH FAILED" build/sim.log; then
    exit 1
fi
exit 0
